//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_imm
	} alu_op_t;

	// Major opcodes of the supported subset.
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_system = 7'b1110011;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt = 7'b0100000;

	localparam word_t inst_ecall = 32'h0000_0073;

	localparam word_t cause_illegal_inst = 32'd2;
	localparam word_t cause_ecall_m = 32'd11;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	import isa_pkg::*;

	// One decoded instruction, as it is held in either slot of the stage.
	typedef struct packed {
		word_t pc;
		word_t ir;
		word_t imm;
		logic rs1_rena;
		reg_addr_t rs1_addr;
		word_t rs1_data;
		logic rs2_rena;
		reg_addr_t rs2_addr;
		word_t rs2_data;
		logic rd_wena;
		reg_addr_t rd_addr;
		logic sel_imm;
		alu_op_t alu_op;
		logic exc_pend;
		word_t exc_cause;
	} id_bundle_t;

endpackage

`default_nettype wire

//--- rtl/inst_decoder.sv
`default_nettype none

module inst_decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input logic [xlen-1:0] pc,
	input word_t ir,
	input logic exc_pend_in,
	input word_t exc_cause_in,
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	output id_bundle_t decoded
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic alt;
	logic illegal;
	logic ecall;
	word_t imm_i;
	word_t imm_u;

	function automatic alu_op_t alu_of(input logic [2:0] f3, input logic alt_sel);
		alu_of = alu_add;
		case (f3)
			f3_add_sub: alu_of = alt_sel ? alu_sub : alu_add;
			f3_sll: alu_of = alu_sll;
			f3_slt: alu_of = alu_slt;
			f3_sltu: alu_of = alu_sltu;
			f3_xor: alu_of = alu_xor;
			f3_srl_sra: alu_of = alt_sel ? alu_sra : alu_srl;
			f3_or: alu_of = alu_or;
			f3_and: alu_of = alu_and;
		endcase
	endfunction

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];
	assign alt = funct7 == f7_alt;
	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_u = {ir[31:12], 12'h000};

	assign rs1_addr = decoded.rs1_addr;
	assign rs2_addr = decoded.rs2_addr;

	always_comb begin
		decoded = '0;
		illegal = 1'b0;
		ecall = 1'b0;
		decoded.pc = pc;
		decoded.ir = ir;
		decoded.rd_addr = ir[11:7];

		case (opcode)
			opc_op: begin
				decoded.rs1_rena = 1'b1;
				decoded.rs2_rena = 1'b1;
				decoded.rd_wena = 1'b1;
				decoded.alu_op = alu_of(funct3, alt);
				// Only ADD/SUB and SRL/SRA have an alternate funct7.
				illegal = !(funct7 == f7_base ||
					(alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra)));
			end
			opc_op_imm: begin
				decoded.rs1_rena = 1'b1;
				decoded.rd_wena = 1'b1;
				decoded.sel_imm = 1'b1;
				decoded.imm = imm_i;
				decoded.alu_op = alu_of(funct3, alt && funct3 == f3_srl_sra);
				if (funct3 == f3_sll)
					illegal = funct7 != f7_base;
				else if (funct3 == f3_srl_sra)
					illegal = funct7 != f7_base && !alt;
			end
			opc_lui: begin
				decoded.rd_wena = 1'b1;
				decoded.sel_imm = 1'b1;
				decoded.imm = imm_u;
				decoded.alu_op = alu_pass_imm;
			end
			opc_system: begin
				ecall = ir == inst_ecall;
				illegal = !ecall;
			end
			default: illegal = 1'b1;
		endcase

		// Unused source fields are zeroed so they never match a forwarding write.
		decoded.rs1_addr = decoded.rs1_rena ? ir[19:15] : '0;
		decoded.rs2_addr = decoded.rs2_rena ? ir[24:20] : '0;

		if (exc_pend_in) begin
			decoded.exc_pend = 1'b1;
			decoded.exc_cause = exc_cause_in;
		end else if (illegal) begin
			decoded.exc_pend = 1'b1;
			decoded.exc_cause = cause_illegal_inst;
		end else if (ecall) begin
			decoded.exc_pend = 1'b1;
			decoded.exc_cause = cause_ecall_m;
		end

		// A trapping instruction must not write its destination.
		if (decoded.exc_pend)
			decoded.rd_wena = 1'b0;
	end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`default_nettype none

module reg_file
	import isa_pkg::*;
(
	input logic clk,
	input logic wena,
	input reg_addr_t waddr,
	input word_t wdata,
	input reg_addr_t raddr1,
	input reg_addr_t raddr2,
	output word_t rdata1,
	output word_t rdata2
);

	// x0 has no storage.
	word_t regs [1:2**reg_addr_w-1];

	always_ff @(posedge clk) begin
		if (wena && waddr != '0)
			regs[waddr] <= wdata;
	end

	// Reads see a write of the same cycle.
	assign rdata1 = (raddr1 == '0) ? '0 :
		(wena && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
		(wena && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

//--- rtl/operand_bypass.sv
`default_nettype none

module operand_bypass
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input id_bundle_t slot,
	input logic rd_wena_ex,
	input reg_addr_t rd_addr_ex,
	input word_t rd_data_ex,
	input logic rd_wena_mem,
	input reg_addr_t rd_addr_mem,
	input word_t rd_data_mem,
	output word_t rs1_data,
	output word_t rs2_data
);

	// EX holds the younger result, so it is checked before MEM.
	function automatic word_t forward(input logic rena, input reg_addr_t addr,
		input word_t data);
		forward = data;
		if (rena && addr != '0) begin
			if (rd_wena_ex && rd_addr_ex == addr)
				forward = rd_data_ex;
			else if (rd_wena_mem && rd_addr_mem == addr)
				forward = rd_data_mem;
		end
	endfunction

	assign rs1_data = forward(slot.rs1_rena, slot.rs1_addr, slot.rs1_data);
	assign rs2_data = forward(slot.rs2_rena, slot.rs2_addr, slot.rs2_data);

endmodule

`default_nettype wire

//--- rtl/id_slots.sv
`default_nettype none

module id_slots
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic load_out,
	input logic load_buf,
	input logic shift_buf,
	input logic ready_in,
	input logic valid_out,
	input id_bundle_t decoded,
	input word_t out_fwd_rs1,
	input word_t out_fwd_rs2,
	input word_t buf_fwd_rs1,
	input word_t buf_fwd_rs2,
	output id_bundle_t slot_out,
	output id_bundle_t slot_buf,
	output logic out_exc_pend
);

	assign out_exc_pend = slot_out.exc_pend;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			slot_out <= '0;
			slot_buf <= '0;
		end else if (flush) begin
			slot_out <= '0;
			slot_buf <= '0;
		end else begin
			// The buffer moves forward with its operands already refreshed.
			if (shift_buf) begin
				slot_out <= slot_buf;
				slot_out.rs1_data <= buf_fwd_rs1;
				slot_out.rs2_data <= buf_fwd_rs2;
			end else if (load_out) begin
				slot_out <= decoded;
			end else if (valid_out && ready_in) begin
				slot_out <= '0;
			end else begin
				slot_out.rs1_data <= out_fwd_rs1;
				slot_out.rs2_data <= out_fwd_rs2;
			end

			if (load_buf) begin
				slot_buf <= decoded;
			end else if (shift_buf) begin
				slot_buf <= '0;
			end else begin
				slot_buf.rs1_data <= buf_fwd_rs1;
				slot_buf.rs2_data <= buf_fwd_rs2;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/id_control.sv
`default_nettype none

module id_control (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic ready_in,
	input logic flush_in,
	input logic out_exc_pend,
	output logic ready_out,
	output logic valid_out,
	output logic flush_out,
	output logic load_out,
	output logic load_buf,
	output logic shift_buf
);

	logic buf_valid;
	logic exc_hold;
	logic accept;

	assign flush_out = flush_in;

	// Once an exception reaches the output, input stays closed until a flush.
	assign ready_out = !buf_valid && !out_exc_pend && !exc_hold && !flush_in;
	assign accept = valid_in && ready_out;

	assign load_out = accept && (!valid_out || ready_in);
	assign load_buf = accept && valid_out && !ready_in;
	assign shift_buf = buf_valid && ready_in && !flush_in;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
			buf_valid <= 1'b0;
			exc_hold <= 1'b0;
		end else if (flush_in) begin
			valid_out <= 1'b0;
			buf_valid <= 1'b0;
			exc_hold <= 1'b0;
		end else begin
			if (out_exc_pend)
				exc_hold <= 1'b1;
			valid_out <= load_out || buf_valid || (valid_out && !ready_in);
			buf_valid <= load_buf || (buf_valid && !ready_in);
		end
	end

endmodule

`default_nettype wire

//--- rtl/id_stage.sv
`default_nettype none

module id_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic ready_in,
	input logic flush_in,
	output logic ready_out,
	output logic valid_out,
	output logic flush_out,
	input word_t pc_in,
	input word_t ir_in,
	input logic exc_pend_in,
	input word_t exc_cause_in,
	input logic rd_wena_ex,
	input reg_addr_t rd_addr_ex,
	input word_t rd_data_ex,
	input logic rd_wena_mem,
	input reg_addr_t rd_addr_mem,
	input word_t rd_data_mem,
	input logic rd_wena_wb,
	input reg_addr_t rd_addr_wb,
	input word_t rd_data_wb,
	output id_bundle_t id_out
);

	id_bundle_t dec_bundle;
	id_bundle_t dec_with_data;
	id_bundle_t slot_out;
	id_bundle_t slot_buf;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t rf_rdata1;
	word_t rf_rdata2;
	word_t out_fwd_rs1;
	word_t out_fwd_rs2;
	word_t buf_fwd_rs1;
	word_t buf_fwd_rs2;
	logic load_out;
	logic load_buf;
	logic shift_buf;
	logic out_exc_pend;

	assign id_out = slot_out;

	always_comb begin
		dec_with_data = dec_bundle;
		dec_with_data.rs1_data = rf_rdata1;
		dec_with_data.rs2_data = rf_rdata2;
	end

	inst_decoder decoder_i (
		.pc(pc_in),
		.ir(ir_in),
		.exc_pend_in(exc_pend_in),
		.exc_cause_in(exc_cause_in),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.decoded(dec_bundle)
	);

	reg_file reg_file_i (
		.clk(clk),
		.wena(rd_wena_wb),
		.waddr(rd_addr_wb),
		.wdata(rd_data_wb),
		.raddr1(rs1_addr),
		.raddr2(rs2_addr),
		.rdata1(rf_rdata1),
		.rdata2(rf_rdata2)
	);

	id_control control_i (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_in(ready_in),
		.flush_in(flush_in),
		.out_exc_pend(out_exc_pend),
		.ready_out(ready_out),
		.valid_out(valid_out),
		.flush_out(flush_out),
		.load_out(load_out),
		.load_buf(load_buf),
		.shift_buf(shift_buf)
	);

	id_slots slots_i (
		.clk(clk),
		.reset(reset),
		.flush(flush_in),
		.load_out(load_out),
		.load_buf(load_buf),
		.shift_buf(shift_buf),
		.ready_in(ready_in),
		.valid_out(valid_out),
		.decoded(dec_with_data),
		.out_fwd_rs1(out_fwd_rs1),
		.out_fwd_rs2(out_fwd_rs2),
		.buf_fwd_rs1(buf_fwd_rs1),
		.buf_fwd_rs2(buf_fwd_rs2),
		.slot_out(slot_out),
		.slot_buf(slot_buf),
		.out_exc_pend(out_exc_pend)
	);

	operand_bypass bypass_out (
		.slot(slot_out),
		.rd_wena_ex(rd_wena_ex),
		.rd_addr_ex(rd_addr_ex),
		.rd_data_ex(rd_data_ex),
		.rd_wena_mem(rd_wena_mem),
		.rd_addr_mem(rd_addr_mem),
		.rd_data_mem(rd_data_mem),
		.rs1_data(out_fwd_rs1),
		.rs2_data(out_fwd_rs2)
	);

	operand_bypass bypass_buf (
		.slot(slot_buf),
		.rd_wena_ex(rd_wena_ex),
		.rd_addr_ex(rd_addr_ex),
		.rd_data_ex(rd_data_ex),
		.rd_wena_mem(rd_wena_mem),
		.rd_addr_mem(rd_addr_mem),
		.rd_data_mem(rd_data_mem),
		.rs1_data(buf_fwd_rs1),
		.rs2_data(buf_fwd_rs2)
	);

endmodule

`default_nettype wire

//--- tb/id_stage_tb.sv
`default_nettype none

module id_stage_tb
	import isa_pkg::*;
	import pipe_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic reset;
	logic valid_in;
	logic ready_in;
	logic flush_in;
	logic ready_out;
	logic valid_out;
	logic flush_out;
	word_t pc_in;
	word_t ir_in;
	logic exc_pend_in;
	word_t exc_cause_in;
	logic rd_wena_ex;
	reg_addr_t rd_addr_ex;
	word_t rd_data_ex;
	logic rd_wena_mem;
	reg_addr_t rd_addr_mem;
	word_t rd_data_mem;
	logic rd_wena_wb;
	reg_addr_t rd_addr_wb;
	word_t rd_data_wb;
	id_bundle_t id_out;

	// Reference copy of the register file, written alongside the writeback port.
	word_t regs [0:31];
	int errors = 0;
	int cycles = 0;

	id_stage dut_i (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= 2000) begin
			$display("Timeout: the tests did not finish within 2000 cycles");
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	task automatic tick();
		@(negedge clk);
	endtask

	task automatic check_val(input string what, input word_t got, input word_t exp);
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic write_reg(input reg_addr_t addr, input word_t data);
		rd_wena_wb = 1'b1;
		rd_addr_wb = addr;
		rd_data_wb = data;
		if (addr != '0)
			regs[addr] = data;
		tick();
		rd_wena_wb = 1'b0;
	endtask

	// Offers one instruction for a single cycle; the stage must be ready.
	task automatic send_inst(input word_t pc, input word_t ir);
		check_val("ready_out before send", 32'(ready_out), 32'd1);
		valid_in = 1'b1;
		pc_in = pc;
		ir_in = ir;
		tick();
		valid_in = 1'b0;
	endtask

	// Raises flush_in for one cycle and checks that it is passed on.
	task automatic pulse_flush();
		flush_in = 1'b1;
		@(posedge clk);
		check_val("flush_out during flush", 32'(flush_out), 32'd1);
		tick();
		flush_in = 1'b0;
	endtask

	task automatic check_inst(input word_t pc, input alu_op_t op, input logic sel,
		input word_t imm, input reg_addr_t rd, input reg_addr_t a1, input reg_addr_t a2,
		input word_t d1, input word_t d2);
		check_val("valid_out", 32'(valid_out), 32'd1);
		check_val("pc", id_out.pc, pc);
		check_val("alu_op", 32'(id_out.alu_op), 32'(op));
		check_val("sel_imm", 32'(id_out.sel_imm), 32'(sel));
		check_val("imm", id_out.imm, imm);
		check_val("rd_addr", 32'(id_out.rd_addr), 32'(rd));
		check_val("rd_wena", 32'(id_out.rd_wena), 32'd1);
		check_val("rs1_addr", 32'(id_out.rs1_addr), 32'(a1));
		check_val("rs2_addr", 32'(id_out.rs2_addr), 32'(a2));
		check_val("rs1_data", id_out.rs1_data, d1);
		check_val("rs2_data", id_out.rs2_data, d2);
		check_val("exc_pend", 32'(id_out.exc_pend), 32'd0);
	endtask

	task automatic reset_and_flow();
		logic [11:0] imm12;
		logic [19:0] imm20;
		check_val("valid_out after reset", 32'(valid_out), 32'd0);
		check_val("ready_out after reset", 32'(ready_out), 32'd1);
		check_val("flush_out without flush", 32'(flush_out), 32'd0);
		for (int i = 1; i < 16; i++)
			write_reg(reg_addr_t'(i), $urandom());
		imm12 = 12'($urandom());
		imm20 = 20'($urandom());
		send_inst(32'h100, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		check_inst(32'h100, alu_add, 1'b0, '0, 5'd3, 5'd1, 5'd2, regs[1], regs[2]);
		send_inst(32'h104, i_type(imm12, 5'd5, 3'b000, 5'd4));
		check_inst(32'h104, alu_add, 1'b1, {{20{imm12[11]}}, imm12}, 5'd4,
			5'd5, 5'd0, regs[5], '0);
		// x0 as a source reads zero.
		send_inst(32'h108, r_type(7'h20, 5'd7, 5'd0, 3'b000, 5'd6));
		check_inst(32'h108, alu_sub, 1'b0, '0, 5'd6, 5'd0, 5'd7, 32'd0, regs[7]);
		send_inst(32'h10c, {imm20, 5'd8, 7'b0110111});
		check_inst(32'h10c, alu_pass_imm, 1'b1, {imm20, 12'h000}, 5'd8,
			5'd0, 5'd0, '0, '0);
		tick();
		check_val("valid_out after drain", 32'(valid_out), 32'd0);
	endtask

	task automatic back_pressure();
		ready_in = 1'b0;
		send_inst(32'h200, r_type(7'h00, 5'd10, 5'd9, 3'b100, 5'd12));
		send_inst(32'h204, r_type(7'h20, 5'd11, 5'd13, 3'b101, 5'd14));
		repeat (3) begin
			check_val("ready_out with buffer full", 32'(ready_out), 32'd0);
			check_inst(32'h200, alu_xor, 1'b0, '0, 5'd12,
				5'd9, 5'd10, regs[9], regs[10]);
			tick();
		end
		ready_in = 1'b1;
		tick();
		check_inst(32'h204, alu_sra, 1'b0, '0, 5'd14, 5'd13, 5'd11, regs[13], regs[11]);
		tick();
		check_val("valid_out after both drained", 32'(valid_out), 32'd0);
		check_val("ready_out after both drained", 32'(ready_out), 32'd1);
	endtask

	task automatic held_forwarding();
		word_t ex_data;
		word_t mem_data;
		ex_data = $urandom();
		mem_data = ~ex_data;
		ready_in = 1'b0;
		send_inst(32'h300, r_type(7'h00, 5'd0, 5'd3, 3'b111, 5'd15));
		check_inst(32'h300, alu_and, 1'b0, '0, 5'd15, 5'd3, 5'd0, regs[3], '0);
		rd_wena_ex = 1'b1;
		rd_addr_ex = 5'd3;
		rd_data_ex = ex_data;
		rd_wena_mem = 1'b1;
		rd_addr_mem = 5'd3;
		rd_data_mem = mem_data;
		tick();
		check_inst(32'h300, alu_and, 1'b0, '0, 5'd15, 5'd3, 5'd0, ex_data, '0);
		rd_wena_ex = 1'b0;
		tick();
		check_inst(32'h300, alu_and, 1'b0, '0, 5'd15, 5'd3, 5'd0, mem_data, '0);
		// Writes to x0 leave the zero operand alone.
		rd_wena_ex = 1'b1;
		rd_addr_ex = 5'd0;
		rd_addr_mem = 5'd0;
		tick();
		check_inst(32'h300, alu_and, 1'b0, '0, 5'd15, 5'd3, 5'd0, mem_data, '0);
		rd_wena_ex = 1'b0;
		rd_wena_mem = 1'b0;
		ready_in = 1'b1;
		tick();
		check_val("valid_out after forwarding drain", 32'(valid_out), 32'd0);
	endtask

	task automatic exception_case(input word_t ir, input logic pend, input word_t cause_in,
		input word_t exp_cause);
		exc_pend_in = pend;
		exc_cause_in = cause_in;
		send_inst(32'h400, ir);
		exc_pend_in = 1'b0;
		check_val("valid_out with exception", 32'(valid_out), 32'd1);
		check_val("exc_pend", 32'(id_out.exc_pend), 32'd1);
		check_val("exc_cause", id_out.exc_cause, exp_cause);
		// New input is offered but must not be taken.
		valid_in = 1'b1;
		ir_in = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
		repeat (3) begin
			check_val("ready_out while exception held", 32'(ready_out), 32'd0);
			tick();
		end
		valid_in = 1'b0;
		check_val("valid_out while input closed", 32'(valid_out), 32'd0);
		pulse_flush();
		check_val("valid_out after flush", 32'(valid_out), 32'd0);
		tick();
		check_val("ready_out after flush", 32'(ready_out), 32'd1);
	endtask

	task automatic flush_both_slots();
		ready_in = 1'b0;
		send_inst(32'h500, r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd5));
		send_inst(32'h504, i_type(12'h7ff, 5'd4, 3'b110, 5'd6));
		check_val("ready_out with both slots full", 32'(ready_out), 32'd0);
		pulse_flush();
		ready_in = 1'b1;
		repeat (4) begin
			check_val("valid_out after flush", 32'(valid_out), 32'd0);
			check_val("pc after flush", id_out.pc, 32'd0);
			tick();
			check_val("ready_out after flush", 32'(ready_out), 32'd1);
		end
	endtask

	initial begin
		void'($urandom(32'habc8_4a04));
		reset = 1'b1;
		valid_in = 1'b0;
		ready_in = 1'b1;
		flush_in = 1'b0;
		pc_in = '0;
		ir_in = '0;
		exc_pend_in = 1'b0;
		exc_cause_in = '0;
		rd_wena_ex = 1'b0;
		rd_addr_ex = '0;
		rd_data_ex = '0;
		rd_wena_mem = 1'b0;
		rd_addr_mem = '0;
		rd_data_mem = '0;
		rd_wena_wb = 1'b0;
		rd_addr_wb = '0;
		rd_data_wb = '0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		tick();

		reset_and_flow();
		back_pressure();
		held_forwarding();
		ready_in = 1'b1;
		exception_case(32'h0000_007f, 1'b0, '0, 32'd2);
		exception_case(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0, '0, 32'd2);
		exception_case(32'h0000_0073, 1'b0, '0, 32'd11);
		exception_case(32'hffff_ffff, 1'b1, 32'd1, 32'd1);
		flush_both_slots();

		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/operand_bypass.sv
rtl/id_slots.sv
rtl/id_control.sv
rtl/id_stage.sv
tb/id_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module id_stage_tb \
	-f filelist.f --Mdir obj_dir -o sim_id_stage
./obj_dir/sim_id_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	exit 0
else
	echo "Simulation did not pass, see sim.log"
	exit 1
fi
